// ==== Makefile ====
TOP := cdbus_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	grep -q "^RESULT: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== flist.f ====
+incdir+hdl
hdl/cdbus_pkg.sv
hdl/cd_ram_if.sv
hdl/cd_frame_ram.sv
hdl/cd_csr.sv
hdl/cd_tx_ser.sv
hdl/cd_rx_des.sv
hdl/cdbus.sv
verif/cdbus_sva.sv
verif/cdbus_tb.sv

// ==== hdl/cd_csr.sv ====
// Host register file: register map, divider, irq and stream access to both frame buffers
`timescale 1ns/1ns
`include "cdbus_config.svh"

module cd_csr import cdbus_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic [4:0] csr_address,
    input  logic       csr_read,
    output byte_t      csr_readdata,
    input  logic       csr_write,
    input  byte_t      csr_writedata,
    output logic       irq,
    cd_ram_if.writer   tx,
    cd_ram_if.reader   rx,
    output div_t       div,
    input  logic       bus_idle,
    input  logic       rx_error,
    input  logic       rx_lost
);

    reg_addr_e  addr;
    byte_t      ctrl;
    logic       err_flag;
    logic       lost_flag;
    frame_len_t tx_ptr;
    ram_addr_t  rx_ptr;
    logic       tx_full;
    logic       rd_rx_dat;
    logic       rd_status;
    byte_t      rd_mux;

    assign addr    = reg_addr_e'(csr_address);
    assign tx_full = (tx_ptr == frame_len_t'(`CD_RAM_DEPTH));

    assign rd_rx_dat = csr_read && (addr == REG_RX_DAT);
    assign rd_status = csr_read && (addr == REG_STATUS);

    // Buffer side of the host port
    assign tx.wr_en      = csr_write && (addr == REG_TX_DAT) && !tx_full;
    assign tx.wr_addr    = ram_addr_t'(tx_ptr);
    assign tx.wr_byte    = csr_writedata;
    assign tx.commit     = csr_write && (addr == REG_TX_CTRL) && csr_writedata[0];
    assign tx.commit_len = tx_ptr;
    assign rx.rd_addr    = rx_ptr;
    assign rx.release_buf = csr_write && (addr == REG_RX_CTRL) && csr_writedata[0];

    assign irq = rx.pending && ctrl[0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl      <= '0;
            div       <= div_t'(`CD_DIV_DEFAULT);
            tx_ptr    <= '0;
            rx_ptr    <= '0;
            err_flag  <= 1'b0;
            lost_flag <= 1'b0;
        end else begin
            if (csr_write) begin
                case (addr)
                    REG_CTRL:  ctrl       <= csr_writedata;
                    REG_DIV_L: div[7:0]   <= csr_writedata;
                    REG_DIV_H: div[15:8]  <= csr_writedata;
                    default:   ;
                endcase
            end
            if (!tx.pending) begin                 // Host fill is dead while tx waits
                if (tx.commit) begin
                    tx_ptr <= '0;
                end else if (tx.wr_en) begin
                    tx_ptr <= tx_ptr + 1'b1;
                end
            end
            if (rx.release_buf) begin
                rx_ptr <= '0;
            end else if (rd_rx_dat) begin
                rx_ptr <= rx_ptr + 1'b1;
            end
            if (rd_status) begin                   // Read to clear
                err_flag  <= 1'b0;
                lost_flag <= 1'b0;
            end
            if (rx_error) err_flag <= 1'b1;
            if (rx_lost) lost_flag <= 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read path, one cycle latency

    always_comb begin
        case (addr)
            REG_VERSION: rd_mux = `CD_VERSION;
            REG_CTRL:    rd_mux = ctrl;
            REG_DIV_L:   rd_mux = div[7:0];
            REG_DIV_H:   rd_mux = div[15:8];
            REG_STATUS:  rd_mux = {3'b000, lost_flag, err_flag, rx.pending, tx.pending, bus_idle};
            REG_RX_LEN:  rd_mux = byte_t'(rx.len);
            REG_RX_DAT:  rd_mux = rx.rd_byte;
            default:     rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            csr_readdata <= '0;
        end else if (csr_read) begin
            csr_readdata <= rd_mux;
        end
    end

endmodule

// ==== hdl/cd_frame_ram.sv ====
// Byte buffer holding one frame with its length and pending flag, one instance per direction
`timescale 1ns/1ns
`include "cdbus_config.svh"

module cd_frame_ram import cdbus_pkg::*; (
    input  logic clk,
    input  logic arst_n,
    cd_ram_if.ram bus
);

    byte_t mem [`CD_RAM_DEPTH];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage

    always_ff @(posedge clk) begin
        if (bus.wr_en && !bus.pending) begin   // Frozen while a frame waits
            mem[bus.wr_addr] <= bus.wr_byte;
        end
    end

    assign bus.rd_byte = mem[bus.rd_addr];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame hand-over

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bus.pending <= 1'b0;
            bus.len     <= '0;
        end else if (bus.release_buf) begin
            bus.pending <= 1'b0;
        end else if (bus.commit && !bus.pending) begin
            bus.pending <= 1'b1;
            bus.len     <= bus.commit_len;
        end
    end

endmodule

// ==== hdl/cd_ram_if.sv ====
// One frame buffer's port bundle, shared by its writer, its reader and the buffer itself
`timescale 1ns/1ns

interface cd_ram_if import cdbus_pkg::*; ();

    logic       wr_en;
    ram_addr_t  wr_addr;
    byte_t      wr_byte;
    ram_addr_t  rd_addr;
    byte_t      rd_byte;      // Combinational from rd_addr
    logic       commit;       // Frame complete, latch commit_len
    frame_len_t commit_len;
    logic       release_buf;  // Reader done with the frame
    frame_len_t len;
    logic       pending;

    modport writer (
        output wr_en, wr_addr, wr_byte, commit, commit_len,
        input  pending
    );

    modport reader (
        output rd_addr, release_buf,
        input  rd_byte, len, pending
    );

    modport ram (
        input  wr_en, wr_addr, wr_byte, rd_addr, commit, commit_len, release_buf,
        output rd_byte, len, pending
    );

endinterface

// ==== hdl/cd_rx_des.sv ====
// Receive deserializer: samples the line, builds bytes, ends frames on idle and commits good ones
`timescale 1ns/1ns
`include "cdbus_config.svh"

module cd_rx_des import cdbus_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  div_t     div,
    input  logic     rx,
    output logic     bus_idle,
    output logic     rx_error,
    output logic     rx_lost,
    cd_ram_if.writer ram
);

    localparam int IW = $clog2(`CD_IDLE_BITS + 1);

    des_state_e    state;
    logic [1:0]    rx_sync;
    logic          line;
    div_t          bit_cnt;
    logic [2:0]    bit_idx;
    logic [IW-1:0] idle_cnt;
    byte_t         shreg;
    crc_t          crc;
    frame_len_t    cnt;
    logic          drop;
    logic          ferr;
    logic          bit_end;
    logic          mid_bit;
    logic          waiting;
    logic          gap_done;
    logic          start_edge;
    logic          room;
    logic          frame_end;

    assign line       = rx_sync[1];
    assign bit_end    = (bit_cnt == div);
    assign mid_bit    = (bit_cnt == (div >> 1));
    assign waiting    = (state == DES_IDLE) || (state == DES_GAP);
    assign gap_done   = waiting && bit_end && (idle_cnt == IW'(`CD_IDLE_BITS - 1));
    assign start_edge = waiting && !line;
    assign room       = (cnt != frame_len_t'(`CD_RAM_DEPTH));
    assign frame_end  = (state == DES_GAP) && !start_edge && gap_done && (cnt != '0) && !drop;

    // Residue of payload plus CRC is zero on a clean frame
    assign ram.wr_en      = (state == DES_STOP) && bit_end && !drop && room;
    assign ram.wr_addr    = ram_addr_t'(cnt);
    assign ram.wr_byte    = shreg;
    assign ram.commit     = frame_end && !ferr && (crc == '0) && (cnt >= frame_len_t'(3));
    assign ram.commit_len = cnt - frame_len_t'(2);

    assign rx_error = frame_end && (ferr || (crc != '0));
    assign rx_lost  = (state == DES_IDLE) && !line && ram.pending;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_sync  <= 2'b11;
            state    <= DES_IDLE;
            bit_cnt  <= '0;
            bit_idx  <= '0;
            idle_cnt <= '0;
            crc      <= '1;
            cnt      <= '0;
            drop     <= 1'b0;
            ferr     <= 1'b0;
            bus_idle <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[0], rx};
            if (bit_end || start_edge || ((state == DES_START) && mid_bit)) begin
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            if (waiting && bit_end) idle_cnt <= idle_cnt + 1'b1;
            case (state)
                DES_IDLE: begin
                    if (gap_done) bus_idle <= 1'b1;
                    if (start_edge) begin              // New frame
                        state    <= DES_START;
                        bus_idle <= 1'b0;
                        crc      <= '1;
                        cnt      <= '0;
                        drop     <= ram.pending;       // Previous frame not yet read
                        ferr     <= 1'b0;
                    end
                end
                DES_GAP: begin
                    if (start_edge) begin
                        state <= DES_START;
                    end else if (gap_done) begin
                        state    <= DES_IDLE;
                        bus_idle <= 1'b1;
                    end
                end
                DES_START: begin
                    if (mid_bit) begin
                        bit_idx  <= '0;
                        idle_cnt <= '0;
                        state    <= line ? DES_GAP : DES_DATA;   // Glitch rejected
                    end
                end
                DES_DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= DES_STOP;
                    end
                end
                DES_STOP: begin
                    if (bit_end) begin
                        state    <= DES_GAP;
                        idle_cnt <= '0;
                        crc      <= crc16_byte(crc, shreg);
                        ferr     <= ferr || !line;     // Framing error
                        if (room) begin
                            cnt <= cnt + 1'b1;
                        end else begin
                            drop <= 1'b1;
                        end
                    end
                end
                default: state <= DES_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == DES_DATA) && bit_end) begin
            shreg <= {line, shreg[7:1]};
        end
    end

endmodule

// ==== hdl/cd_tx_ser.sv ====
// Transmit serializer: sends the tx buffer as UART characters plus CRC once the bus is idle
`timescale 1ns/1ns

module cd_tx_ser import cdbus_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  div_t     div,
    input  logic     bus_idle,
    cd_ram_if.reader ram,
    output logic     tx,
    output logic     tx_en
);

    ser_state_e state;
    div_t       bit_cnt;
    logic [2:0] bit_idx;
    frame_len_t byte_idx;     // Payload bytes, then CRC low and high
    byte_t      shreg;
    crc_t       crc;
    byte_t      cur_byte;
    logic       bit_end;
    logic       is_payload;
    logic       frame_done;
    logic       load;

    assign bit_end    = (bit_cnt == div);
    assign is_payload = (byte_idx < ram.len);
    assign frame_done = (byte_idx == ram.len + frame_len_t'(2));
    assign load       = ((state == SER_WAIT_IDLE) && bus_idle)
                     || ((state == SER_STOP) && bit_end && !frame_done);

    always_comb begin
        if (is_payload) begin
            cur_byte = ram.rd_byte;
        end else if (byte_idx == ram.len) begin
            cur_byte = crc[7:0];                   // CRC goes out low byte first
        end else begin
            cur_byte = crc[15:8];
        end
    end

    assign ram.rd_addr     = ram_addr_t'(byte_idx);
    assign ram.release_buf = (state == SER_STOP) && bit_end && frame_done;

    assign tx_en = (state == SER_START) || (state == SER_DATA) || (state == SER_STOP);
    assign tx    = (state == SER_START) ? 1'b0 : (state == SER_DATA) ? shreg[0] : 1'b1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= SER_IDLE;
            bit_cnt  <= '0;
            bit_idx  <= '0;
            byte_idx <= '0;
            crc      <= '1;
        end else begin
            bit_cnt <= (tx_en && !bit_end) ? bit_cnt + 1'b1 : '0;
            if (load && is_payload) crc <= crc16_byte(crc, cur_byte);
            case (state)
                SER_IDLE: begin
                    byte_idx <= '0;
                    crc      <= '1;
                    if (ram.pending) state <= SER_WAIT_IDLE;
                end
                SER_WAIT_IDLE: if (bus_idle) state <= SER_START;
                SER_START: begin
                    if (bit_end) begin
                        state   <= SER_DATA;
                        bit_idx <= '0;
                    end
                end
                SER_DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state    <= SER_STOP;
                            byte_idx <= byte_idx + 1'b1;
                        end
                    end
                end
                SER_STOP: if (bit_end) state <= frame_done ? SER_IDLE : SER_START;
                default:  state <= SER_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            shreg <= cur_byte;
        end else if ((state == SER_DATA) && bit_end) begin
            shreg <= shreg >> 1;                   // LSB first
        end
    end

endmodule

// ==== hdl/cdbus.sv ====
// CDBUS controller top level, register port on one side and the bus line on the other
`timescale 1ns/1ns

module cdbus import cdbus_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic [4:0] csr_address,
    input  logic       csr_read,
    output logic [7:0] csr_readdata,
    input  logic       csr_write,
    input  logic [7:0] csr_writedata,
    output logic       irq,
    input  logic       rx,
    output logic       tx,
    output logic       tx_en
);

    div_t div;
    logic bus_idle;
    logic rx_error;
    logic rx_lost;

    cd_ram_if tx_buf ();    // Host to line
    cd_ram_if rx_buf ();    // Line to host

    cd_frame_ram u_tx_ram (
        .clk    (clk),
        .arst_n (arst_n),
        .bus    (tx_buf)
    );

    cd_frame_ram u_rx_ram (
        .clk    (clk),
        .arst_n (arst_n),
        .bus    (rx_buf)
    );

    cd_csr u_csr (
        .clk           (clk),
        .arst_n        (arst_n),
        .csr_address   (csr_address),
        .csr_read      (csr_read),
        .csr_readdata  (csr_readdata),
        .csr_write     (csr_write),
        .csr_writedata (csr_writedata),
        .irq           (irq),
        .tx            (tx_buf),
        .rx            (rx_buf),
        .div           (div),
        .bus_idle      (bus_idle),
        .rx_error      (rx_error),
        .rx_lost       (rx_lost)
    );

    cd_tx_ser u_tx_ser (
        .clk      (clk),
        .arst_n   (arst_n),
        .div      (div),
        .bus_idle (bus_idle),
        .ram      (tx_buf),
        .tx       (tx),
        .tx_en    (tx_en)
    );

    cd_rx_des u_rx_des (
        .clk      (clk),
        .arst_n   (arst_n),
        .div      (div),
        .rx       (rx),
        .bus_idle (bus_idle),
        .rx_error (rx_error),
        .rx_lost  (rx_lost),
        .ram      (rx_buf)
    );

endmodule

// ==== hdl/cdbus_config.svh ====
// Build-time constants for the CDBUS controller, included by the package and by the RTL that uses them
`ifndef CDBUS_CONFIG_SVH
`define CDBUS_CONFIG_SVH

// Frame buffer size in bytes, payload plus CRC
`define CD_RAM_DEPTH 64

// Clocks per bit minus one after reset
`define CD_DIV_DEFAULT 7

// Idle bit times that close a frame
`define CD_IDLE_BITS 12

`define CD_VERSION 8'h01

`endif

// ==== hdl/cdbus_pkg.sv ====
// Types and the CRC-16 byte update shared by every CDBUS block, imported by wildcard
`include "cdbus_config.svh"

package cdbus_pkg;

    typedef logic [7:0]                         byte_t;
    typedef logic [$clog2(`CD_RAM_DEPTH)-1:0]   ram_addr_t;
    typedef logic [$clog2(`CD_RAM_DEPTH):0]     frame_len_t;
    typedef logic [15:0]                        div_t;
    typedef logic [15:0]                        crc_t;

    typedef enum logic [4:0] {
        REG_VERSION = 5'h00,
        REG_CTRL    = 5'h01,    // Bit 0 rx irq enable
        REG_DIV_L   = 5'h02,
        REG_DIV_H   = 5'h03,
        REG_STATUS  = 5'h04,
        REG_TX_DAT  = 5'h05,
        REG_TX_CTRL = 5'h06,
        REG_RX_LEN  = 5'h07,
        REG_RX_DAT  = 5'h08,
        REG_RX_CTRL = 5'h09
    } reg_addr_e;

    typedef enum logic [2:0] {
        SER_IDLE, SER_WAIT_IDLE, SER_START, SER_DATA, SER_STOP
    } ser_state_e;

    typedef enum logic [2:0] {
        DES_IDLE, DES_START, DES_DATA, DES_STOP, DES_GAP
    } des_state_e;

    // Modbus CRC-16, reflected polynomial, one byte LSB first
    function automatic crc_t crc16_byte(crc_t crc, byte_t data);
        crc_t c;
        c = crc ^ crc_t'(data);
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ 16'hA001) : (c >> 1);
        end
        return c;
    endfunction

endpackage

// ==== verif/cdbus_sva.sv ====
// Line protocol and buffer flag assertions, bound into the serializer and the deserializer
`timescale 1ns/1ns

module cdbus_sva (
    input logic clk,
    input logic arst_n,
    input logic tx,
    input logic tx_en,
    input logic wr_en,
    input logic pending
);

    int unsigned fails = 0;    // Assertion failure count

    // Line rests high whenever the driver is off
    a_line_idle: assert property (@(posedge clk) disable iff (!arst_n) !tx_en |-> tx)
        else begin
            $error("tx low while tx_en is off");
            fails++;
        end

    a_en_needs_frame: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(tx_en) |-> pending)
        else begin
            $error("tx_en rose with no pending frame");
            fails++;
        end

    a_no_write_pending: assert property (@(posedge clk) disable iff (!arst_n)
        wr_en |-> !pending)
        else begin
            $error("buffer written while its frame is pending");
            fails++;
        end

endmodule

bind cd_tx_ser cdbus_sva u_sva (
    .clk     (clk),
    .arst_n  (arst_n),
    .tx      (tx),
    .tx_en   (tx_en),
    .wr_en   (1'b0),
    .pending (ram.pending)
);

bind cd_rx_des cdbus_sva u_sva (
    .clk     (clk),
    .arst_n  (arst_n),
    .tx      (1'b1),
    .tx_en   (1'b0),
    .wr_en   (ram.wr_en),
    .pending (ram.pending)
);

// ==== verif/cdbus_tb.sv ====
// Directed loopback testbench that checks the CDBUS controller through its host registers
`timescale 1ns/1ns
`include "cdbus_config.svh"

module cdbus_tb import cdbus_pkg::*; ();

    localparam int MAX_PAYLOAD = 20;
    localparam int SLOW_DIV    = 20;
    // Longest frame in bit times with CRC and an idle gap on each side
    localparam int MAX_BITS    = (MAX_PAYLOAD + 2) * 10 + 2 * `CD_IDLE_BITS;
    localparam int FRAMES      = 5;
    localparam int WATCHDOG_NS = 3 * FRAMES * MAX_BITS * (SLOW_DIV + 1) * 4;

    logic       clk;
    logic       arst_n;
    logic [4:0] csr_address;
    logic       csr_read;
    logic [7:0] csr_readdata;
    logic       csr_write;
    logic [7:0] csr_writedata;
    logic       irq;
    logic       tx;
    logic       tx_en;
    logic       line;
    logic       corrupt;           // Inverts the looped-back line

    int         errors;
    int         asserts;
    int         bit_clks;          // Clocks per bit as programmed
    byte_t      payload[$];
    byte_t      line_bytes[$];

    assign line = tx ^ corrupt;

    cdbus u_dut (
        .clk           (clk),
        .arst_n        (arst_n),
        .csr_address   (csr_address),
        .csr_read      (csr_read),
        .csr_readdata  (csr_readdata),
        .csr_write     (csr_write),
        .csr_writedata (csr_writedata),
        .irq           (irq),
        .rx            (line),
        .tx            (tx),
        .tx_en         (tx_en)
    );

    always #2 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("FAILED %s: got 0x%0h, expected 0x%0h at %0t ns",
                     name, got, expected, $time);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        arst_n = 1'b0;
        repeat (16) @(negedge clk);
        arst_n   = 1'b1;
        bit_clks = `CD_DIV_DEFAULT + 1;
    endtask

    task automatic csr_wr(input logic [4:0] addr, input byte_t data);
        @(negedge clk);
        csr_address   = addr;
        csr_writedata = data;
        csr_write     = 1'b1;
        @(negedge clk);
        csr_write     = 1'b0;
    endtask

    task automatic csr_rd(input logic [4:0] addr, output byte_t data);
        @(negedge clk);
        csr_address = addr;
        csr_read    = 1'b1;
        @(negedge clk);
        csr_read    = 1'b0;
        data        = csr_readdata;     // Registered one cycle after the strobe
    endtask

    task automatic set_div(input int value);
        csr_wr(REG_DIV_L, byte_t'(value));
        csr_wr(REG_DIV_H, byte_t'(value >> 8));
        bit_clks = value + 1;
    endtask

    // Modbus CRC-16 worked bit by bit from the LSB
    function automatic logic [15:0] crc16_model(input byte_t data[$]);
        logic [15:0] crc;
        logic        fb;
        crc = 16'hffff;
        foreach (data[i]) begin
            for (int b = 0; b < 8; b++) begin
                fb  = crc[0] ^ data[i][b];
                crc = crc >> 1;
                if (fb) crc = crc ^ 16'ha001;
            end
        end
        return crc;
    endfunction

    task automatic make_payload();
        int len;
        len = $urandom_range(MAX_PAYLOAD, 1);
        payload.delete();
        repeat (len) payload.push_back(byte_t'($urandom));
    endtask

    task automatic send_frame();
        foreach (payload[i]) csr_wr(REG_TX_DAT, payload[i]);
        csr_wr(REG_TX_CTRL, 8'h01);
    endtask

    task automatic release_rx();
        csr_wr(REG_RX_CTRL, 8'h01);
    endtask

    task automatic wait_tx_en(input logic level);
        int n;
        n = 0;
        while (tx_en !== level && n < 4 * MAX_BITS * bit_clks) begin
            @(negedge clk);
            n++;
        end
        if (tx_en !== level) begin
            errors++;
            $display("Timed out waiting for tx_en to go %0b", level);
        end
    endtask

    task automatic wait_tx_done();
        wait_tx_en(1'b1);
        wait_tx_en(1'b0);
    endtask

    task automatic wait_irq();
        int n;
        n = 0;
        while (irq !== 1'b1 && n < 4 * MAX_BITS * bit_clks) begin
            @(negedge clk);
            n++;
        end
        if (irq !== 1'b1) begin
            errors++;
            $display("Timed out waiting for the receive interrupt");
        end
    endtask

    // Polls STATUS until the receiver reports an idle bus
    task automatic wait_bus_idle(output byte_t status);
        int n;
        n = 0;
        csr_rd(REG_STATUS, status);
        while (!status[0] && n < 4 * MAX_BITS * bit_clks) begin
            csr_rd(REG_STATUS, status);
            n++;
        end
        if (!status[0]) begin
            errors++;
            $display("Timed out waiting for the bus to go idle");
        end
    endtask

    // Samples the tx line mid-bit and collects every character of one frame
    task automatic capture_line();
        byte_t b;
        line_bytes.delete();
        wait_tx_en(1'b1);
        while (tx_en) begin
            if (!tx) begin
                repeat (bit_clks / 2) @(negedge clk);
                check_eq("tx start bit", tx, 0);
                for (int i = 0; i < 8; i++) begin
                    repeat (bit_clks) @(negedge clk);
                    b[i] = tx;
                end
                repeat (bit_clks) @(negedge clk);
                check_eq("tx stop bit", tx, 1);
                line_bytes.push_back(b);
            end
            @(negedge clk);
        end
    endtask

    // Inverts data bit 0 of the first character
    task automatic flip_data_bit();
        wait_tx_en(1'b1);
        repeat (bit_clks) @(negedge clk);     // Skip the start bit
        corrupt = 1'b1;
        repeat (bit_clks) @(negedge clk);
        corrupt = 1'b0;
    endtask

    task automatic check_rx_frame(input byte_t expected[$]);
        byte_t d;
        csr_rd(REG_RX_LEN, d);
        check_eq("RX_LEN", d, expected.size());
        foreach (expected[i]) begin
            csr_rd(REG_RX_DAT, d);
            check_eq("RX_DAT", d, expected[i]);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tests

    task automatic reset_values();
        byte_t d;
        check_eq("irq", irq, 0);
        check_eq("tx_en", tx_en, 0);
        check_eq("tx", tx, 1);
        csr_rd(REG_STATUS, d);
        check_eq("STATUS flags", d[4:1], 0);    // Pending and sticky bits
        csr_rd(REG_DIV_L, d);
        check_eq("DIV_L", d, `CD_DIV_DEFAULT & 8'hff);
        csr_rd(REG_DIV_H, d);
        check_eq("DIV_H", d, (`CD_DIV_DEFAULT >> 8) & 8'hff);
        csr_rd(REG_VERSION, d);
        check_eq("VERSION", d, `CD_VERSION);
    endtask

    task automatic register_access();
        byte_t d;
        csr_wr(REG_DIV_L, 8'h5a);
        csr_wr(REG_DIV_H, 8'ha5);
        csr_wr(REG_CTRL, 8'h3c);
        csr_rd(REG_DIV_L, d);
        check_eq("DIV_L", d, 8'h5a);
        csr_rd(REG_DIV_H, d);
        check_eq("DIV_H", d, 8'ha5);
        csr_rd(REG_CTRL, d);
        check_eq("CTRL", d, 8'h3c);
    endtask

    task automatic loopback_frame();
        byte_t d;
        csr_wr(REG_CTRL, 8'h01);              // Rx irq on
        make_payload();
        send_frame();
        wait_irq();
        check_rx_frame(payload);
        release_rx();
        csr_rd(REG_STATUS, d);
        check_eq("STATUS rx_pending", d[2], 0);
        check_eq("irq", irq, 0);
    endtask

    task automatic slow_divider();
        logic [15:0] crc;
        byte_t       expected[$];
        byte_t       d;
        set_div(SLOW_DIV);
        make_payload();
        crc = crc16_model(payload);
        fork
            capture_line();
            begin
                send_frame();
                wait_irq();
            end
        join
        check_rx_frame(payload);
        release_rx();
        csr_rd(REG_STATUS, d);
        check_eq("STATUS rx_pending", d[2], 0);
        check_eq("irq", irq, 0);
        expected = payload;
        expected.push_back(crc[7:0]);         // CRC low byte first
        expected.push_back(crc[15:8]);
        check_eq("tx byte count", line_bytes.size(), expected.size());
        foreach (line_bytes[i]) begin
            if (i < expected.size()) check_eq("tx line byte", line_bytes[i], expected[i]);
        end
        set_div(`CD_DIV_DEFAULT);
    endtask

    task automatic crc_error();
        byte_t d;
        make_payload();
        fork
            send_frame();
            flip_data_bit();
        join
        wait_tx_done();
        wait_bus_idle(d);
        check_eq("STATUS rx_error", d[3], 1);
        check_eq("STATUS rx_pending", d[2], 0);
        check_eq("irq", irq, 0);
        csr_rd(REG_STATUS, d);
        check_eq("STATUS rx_error", d[3], 0);  // Cleared by the read before
    endtask

    task automatic overrun();
        byte_t d;
        byte_t first[$];
        make_payload();
        first = payload;
        send_frame();
        wait_irq();
        make_payload();                       // Second frame while rx is still held
        send_frame();
        wait_tx_done();
        csr_rd(REG_STATUS, d);
        check_eq("STATUS rx_lost", d[4], 1);
        check_eq("STATUS rx_pending", d[2], 1);
        check_rx_frame(first);
        release_rx();
        wait_bus_idle(d);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sequence and watchdog

    initial begin
        clk           = 1'b0;
        arst_n        = 1'b0;
        csr_address   = '0;
        csr_read      = 1'b0;
        csr_write     = 1'b0;
        csr_writedata = '0;
        corrupt       = 1'b0;
        errors        = 0;
        asserts       = 0;
        bit_clks      = `CD_DIV_DEFAULT + 1;
        void'($urandom(32'he8d0));
        apply_reset();
        reset_values();
        register_access();
        apply_reset();                        // Back to the default divider
        loopback_frame();
        slow_divider();
        crc_error();
        overrun();
        asserts = u_dut.u_tx_ser.u_sva.fails + u_dut.u_rx_des.u_sva.fails;
        $display("Tests done: %0d check errors, %0d assertion failures", errors, asserts);
        if (errors == 0 && asserts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule
